// ==== include/huff_cfg.svh ====
`ifndef HUFF_CFG_SVH
`define HUFF_CFG_SVH

// sram geometry
`define HUFF_ADDR_W       10
`define HUFF_DATA_W       8

// symbols 1..6 are counted, everything else is filler
`define HUFF_SYMBOLS      6
`define HUFF_COUNT_W      8

// one input block per reset
`define HUFF_BLOCK_LEN    100

// memory map
`define HUFF_INPUT_BASE   0
`define HUFF_RESULT_BASE  128   // two words per rank, symbol then count

`endif

// ==== rtl/huff_sram_pkg.sv ====
`include "huff_cfg.svh"

package huff_sram_pkg;

    // address into the single port sram
    typedef logic [`HUFF_ADDR_W-1:0] sram_addr_t;

    // one sram data word
    typedef logic [`HUFF_DATA_W-1:0] sram_word_t;

endpackage

// ==== rtl/huff_rank_pkg.sv ====
`include "huff_cfg.svh"

package huff_rank_pkg;

    // symbol number, 1..6 (0 never counted)
    typedef logic [$clog2(`HUFF_SYMBOLS + 1)-1:0] symbol_t;

    typedef logic [`HUFF_COUNT_W-1:0] count_t;

    // position in the ranked table, 0 is most frequent
    typedef logic [$clog2(`HUFF_SYMBOLS)-1:0] rank_t;

    // slot i holds the count of symbol i+1
    typedef count_t [`HUFF_SYMBOLS-1:0] count_vec_t;

endpackage

// ==== rtl/symbol_reader.sv ====
`timescale 1ns/1ps
`include "huff_cfg.svh"

module symbol_reader
    import huff_sram_pkg::*;
    import huff_rank_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  sram_word_t sram_q,
    output sram_addr_t rd_addr,
    output logic       sym_valid,
    output symbol_t    sym_value,
    output logic       read_done
);

    localparam sram_addr_t LAST_INDEX = sram_addr_t'(`HUFF_BLOCK_LEN - 1);

    sram_addr_t rd_index;
    logic       sweep_done;
    logic       q_valid;     // sram_q carries a block word this cycle
    logic       q_last;
    logic       sym_last;
    logic       in_range;

    assign rd_addr  = sram_addr_t'(`HUFF_INPUT_BASE) + rd_index;
    assign in_range = (sram_q >= sram_word_t'(1)) &&
                      (sram_q <= sram_word_t'(`HUFF_SYMBOLS));

    // one sweep over the block, then hold
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_index   <= '0;
            sweep_done <= 1'b0;
        end else if (!sweep_done) begin
            if (rd_index == LAST_INDEX)
                sweep_done <= 1'b1;
            else
                rd_index <= rd_index + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_valid   <= 1'b0;
            q_last    <= 1'b0;
            sym_valid <= 1'b0;
            sym_last  <= 1'b0;
            read_done <= 1'b0;
        end else begin
            q_valid   <= !sweep_done;    // sram latency of one cycle
            q_last    <= !sweep_done && (rd_index == LAST_INDEX);
            sym_valid <= q_valid && in_range;
            sym_last  <= q_last;
            read_done <= sym_last;
        end
    end

    always_ff @(posedge clk) begin
        if (q_valid && in_range)
            sym_value <= symbol_t'(sram_q);
    end

    a_sym_in_range: assert property (@(posedge clk) disable iff (reset)
        sym_valid |-> (sym_value != '0) && (sym_value <= symbol_t'(`HUFF_SYMBOLS)));

endmodule

// ==== rtl/symbol_bin.sv ====
`timescale 1ns/1ps

module symbol_bin
    import huff_rank_pkg::*;
#(
    parameter symbol_t SYMBOL = symbol_t'(1)
)
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sym_valid,
    input  symbol_t sym_value,
    output count_t  count
);

    logic hit;

    assign hit = sym_valid && (sym_value == SYMBOL);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            count <= '0;
        else if (hit)
            count <= count + 1'b1;
    end

    // block length must fit the counter width
    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        (count == '1) |=> (count != '0));

endmodule

// ==== rtl/rank_sorter.sv ====
`timescale 1ns/1ps
`include "huff_cfg.svh"

module rank_sorter
    import huff_rank_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       read_done,
    input  count_vec_t counts,
    output logic       rank_valid,
    output symbol_t    rank_symbol,
    output count_t     rank_count
);

    localparam int GRP = `HUFF_SYMBOLS / 2;   // group a is 0..2, group b is 3..5

    typedef enum logic [2:0] {
        S_IDLE,
        S_SORT12,
        S_SORT23,
        S_SORT21,
        S_MERGE,
        S_DONE
    } state_t;

    state_t     state;
    symbol_t    sym_r [`HUFF_SYMBOLS];
    count_t     cnt_r [`HUFF_SYMBOLS];
    logic [1:0] ptr_a;
    logic [1:0] ptr_b;
    rank_t      out_cnt;
    logic       sorting;
    logic       cas_lo;    // 0 swaps positions 1-2, 1 swaps 2-3
    logic       a_empty;
    logic       b_empty;
    logic       take_a;
    logic [2:0] idx_a;
    logic [2:0] idx_b;

    // higher count first, lower symbol breaks a tie
    function automatic logic ranks_before(symbol_t sa, count_t ca, symbol_t sb, count_t cb);
        return (ca > cb) || ((ca == cb) && (sa < sb));
    endfunction

    assign sorting = (state == S_SORT12) || (state == S_SORT23) || (state == S_SORT21);
    assign cas_lo  = (state == S_SORT23);

    // merge heads, exhaustion tracked by pointer so zero counts still rank
    assign a_empty = (ptr_a == 2'(GRP));
    assign b_empty = (ptr_b == 2'(GRP));
    assign idx_a   = {1'b0, ptr_a};
    assign idx_b   = b_empty ? 3'(GRP) : 3'(GRP) + {1'b0, ptr_b};
    assign take_a  = !a_empty &&
                     (b_empty || ranks_before(sym_r[idx_a], cnt_r[idx_a],
                                              sym_r[idx_b], cnt_r[idx_b]));

    assign rank_valid  = (state == S_MERGE);
    assign rank_symbol = take_a ? sym_r[idx_a] : sym_r[idx_b];
    assign rank_count  = take_a ? cnt_r[idx_a] : cnt_r[idx_b];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= S_IDLE;
            ptr_a   <= '0;
            ptr_b   <= '0;
            out_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (read_done)
                        state <= S_SORT12;
                end
                S_SORT12: state <= S_SORT23;
                S_SORT23: state <= S_SORT21;
                S_SORT21: state <= S_MERGE;
                S_MERGE: begin
                    if (take_a)
                        ptr_a <= ptr_a + 1'b1;
                    else
                        ptr_b <= ptr_b + 1'b1;
                    out_cnt <= out_cnt + 1'b1;
                    if (out_cnt == rank_t'(`HUFF_SYMBOLS - 1))
                        state <= S_DONE;
                end
                default: state <= S_DONE;   // hold until next reset
            endcase
        end
    end

    // counts are final in the read_done cycle
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && read_done) begin
            for (int i = 0; i < `HUFF_SYMBOLS; i++) begin
                sym_r[i] <= symbol_t'(i + 1);
                cnt_r[i] <= counts[i];
            end
        end else if (sorting) begin
            // same compare-and-swap step in both groups
            for (int g = 0; g < `HUFF_SYMBOLS; g += GRP) begin
                if (ranks_before(sym_r[g + cas_lo + 1], cnt_r[g + cas_lo + 1],
                                 sym_r[g + cas_lo], cnt_r[g + cas_lo])) begin
                    sym_r[g + cas_lo]     <= sym_r[g + cas_lo + 1];
                    cnt_r[g + cas_lo]     <= cnt_r[g + cas_lo + 1];
                    sym_r[g + cas_lo + 1] <= sym_r[g + cas_lo];
                    cnt_r[g + cas_lo + 1] <= cnt_r[g + cas_lo];
                end
            end
        end
    end

    a_six_ranks: assert property (@(posedge clk) disable iff (reset)
        $rose(rank_valid) |-> rank_valid [*`HUFF_SYMBOLS] ##1 !rank_valid);

endmodule

// ==== rtl/rank_writer.sv ====
`timescale 1ns/1ps
`include "huff_cfg.svh"

module rank_writer
    import huff_sram_pkg::*;
    import huff_rank_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  sram_addr_t rd_addr,
    input  logic       rank_valid,
    input  symbol_t    rank_symbol,
    input  count_t     rank_count,
    output sram_addr_t sram_a,
    output sram_word_t sram_d,
    output logic       sram_wen,
    output logic       finish
);

    localparam int RESULT_WORDS = 2 * `HUFF_SYMBOLS;

    symbol_t    buf_sym [`HUFF_SYMBOLS];
    count_t     buf_cnt [`HUFF_SYMBOLS];
    rank_t      in_rank;
    logic       writing;
    logic [3:0] wr_idx;    // even words symbol, odd words count
    rank_t      wr_rank;

    assign wr_rank = rank_t'(wr_idx >> 1);

    // read sweep owns the address until the table goes out
    assign sram_a   = writing ? sram_addr_t'(`HUFF_RESULT_BASE) + sram_addr_t'(wr_idx)
                              : rd_addr;
    assign sram_d   = wr_idx[0] ? sram_word_t'(buf_cnt[wr_rank])
                                : sram_word_t'(buf_sym[wr_rank]);
    assign sram_wen = writing;

    always_ff @(posedge clk) begin
        if (rank_valid) begin
            buf_sym[in_rank] <= rank_symbol;
            buf_cnt[in_rank] <= rank_count;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_rank <= '0;
            writing <= 1'b0;
            wr_idx  <= '0;
            finish  <= 1'b0;
        end else begin
            if (rank_valid) begin
                in_rank <= in_rank + 1'b1;
                if (in_rank == rank_t'(`HUFF_SYMBOLS - 1))
                    writing <= 1'b1;   // last entry buffered
            end
            if (writing) begin
                if (wr_idx == 4'(RESULT_WORDS - 1)) begin
                    writing <= 1'b0;
                    finish  <= 1'b1;   // sticky until reset
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
        end
    end

    // the input block must survive the run, and writes stay inside the table
    a_wr_result_only: assert property (@(posedge clk) disable iff (reset)
        sram_wen |-> (sram_a >= sram_addr_t'(`HUFF_RESULT_BASE)) &&
                     (sram_a < sram_addr_t'(`HUFF_RESULT_BASE + RESULT_WORDS)));

endmodule

// ==== rtl/huff_freq_rank.sv ====
`timescale 1ns/1ps
`include "huff_cfg.svh"

module huff_freq_rank
    import huff_sram_pkg::*;
    import huff_rank_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  sram_word_t sram_q,
    output sram_addr_t sram_a,
    output sram_word_t sram_d,
    output logic       sram_wen,
    output logic       finish
);

    sram_addr_t rd_addr;
    logic       sym_valid;
    symbol_t    sym_value;
    logic       read_done;
    count_vec_t counts;
    logic       rank_valid;
    symbol_t    rank_symbol;
    count_t     rank_count;

    symbol_reader i_symbol_reader (
        .clk       (clk),
        .reset     (reset),
        .sram_q    (sram_q),
        .rd_addr   (rd_addr),
        .sym_valid (sym_valid),
        .sym_value (sym_value),
        .read_done (read_done)
    );

    // one counter per symbol value
    for (genvar g = 0; g < `HUFF_SYMBOLS; g++) begin : g_bin
        symbol_bin #(
            .SYMBOL (symbol_t'(g + 1))
        ) i_symbol_bin (
            .clk       (clk),
            .reset     (reset),
            .sym_valid (sym_valid),
            .sym_value (sym_value),
            .count     (counts[g])
        );
    end

    rank_sorter i_rank_sorter (
        .clk         (clk),
        .reset       (reset),
        .read_done   (read_done),
        .counts      (counts),
        .rank_valid  (rank_valid),
        .rank_symbol (rank_symbol),
        .rank_count  (rank_count)
    );

    rank_writer i_rank_writer (
        .clk         (clk),
        .reset       (reset),
        .rd_addr     (rd_addr),
        .rank_valid  (rank_valid),
        .rank_symbol (rank_symbol),
        .rank_count  (rank_count),
        .sram_a      (sram_a),
        .sram_d      (sram_d),
        .sram_wen    (sram_wen),
        .finish      (finish)
    );

endmodule

// ==== test/tb_sram_model.sv ====
`timescale 1ns/1ps
`include "huff_cfg.svh"

module tb_sram_model
    import huff_sram_pkg::*;
(
    input  logic       clk,
    input  sram_addr_t a,
    input  sram_word_t d,
    input  logic       wen,
    output sram_word_t q
);

    localparam int DEPTH = 1 << `HUFF_ADDR_W;

    sram_word_t mem [DEPTH];
    int         input_writes = 0;   // writes that landed inside the input block

    // read-first, one cycle latency
    always @(posedge clk) begin
        if (wen) begin
            mem[a] <= d;
            if ((int'(a) >= `HUFF_INPUT_BASE) &&
                (int'(a) < `HUFF_INPUT_BASE + `HUFF_BLOCK_LEN))
                input_writes <= input_writes + 1;
        end
        q <= mem[a];
    end

    // backdoor access
    task automatic load_word(input sram_addr_t addr, input sram_word_t data);
        mem[addr] = data;
    endtask

    task automatic read_word(input sram_addr_t addr, output sram_word_t data);
        data = mem[addr];
    endtask

    task automatic get_input_writes(output int n);
        n = input_writes;
    endtask

endmodule

// ==== test/tb_huff_rank.sv ====
`timescale 1ns/1ps
`include "huff_cfg.svh"

module tb_huff_rank
    import huff_sram_pkg::*;
    import huff_rank_pkg::*;
();

    localparam int NUM_ROWS       = 6;
    localparam int NSYM           = `HUFF_SYMBOLS;
    localparam int LEN            = `HUFF_BLOCK_LEN;
    localparam int TIMEOUT_CYCLES = 1000;
    localparam int HOLD_CYCLES    = 20;

    logic       clk;
    logic       reset;
    sram_addr_t sram_a;
    sram_word_t sram_d;
    sram_word_t sram_q;
    logic       sram_wen;
    logic       finish;

    // wanted count per symbol 1..6, filler makes up the rest of the block
    int row_counts [NUM_ROWS][NSYM] = '{
        '{30,  5, 20, 10, 25,  8},   // all distinct
        '{20, 15, 20, 15, 10, 10},   // pairwise ties
        '{ 0,  0,  0, 100, 0,  0},   // one symbol takes the block
        '{12,  0,  0, 30,  0, 50},
        '{ 3,  1,  3,  0,  2,  1},   // mostly filler
        '{16, 16, 16, 16, 16, 16}
    };
    int row_filler [NUM_ROWS] = '{2, 10, 0, 8, 90, 4};

    sram_word_t block   [LEN];
    int         exp_sym [NSYM];
    int         exp_cnt [NSYM];

    always #2 clk = ~clk;

    huff_freq_rank i_huff_freq_rank (
        .clk      (clk),
        .reset    (reset),
        .sram_q   (sram_q),
        .sram_a   (sram_a),
        .sram_d   (sram_d),
        .sram_wen (sram_wen),
        .finish   (finish)
    );

    tb_sram_model i_sram_model (
        .clk (clk),
        .a   (sram_a),
        .d   (sram_d),
        .wen (sram_wen),
        .q   (sram_q)
    );

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL at %0t ns: %s, expected %0d, got %0d", $time, what, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    endtask

    // depends on every address bit
    function automatic sram_word_t scrub_word(sram_addr_t addr);
        return sram_word_t'(addr) ^ sram_word_t'(addr >> 8) ^ 8'h5a;
    endfunction

    task automatic build_block(input int row);
        int         n;
        int         j;
        int         r;
        sram_word_t tmp;
        n = 0;
        for (int s = 0; s < NSYM; s++) begin
            for (int k = 0; k < row_counts[row][s]; k++) begin
                block[n] = sram_word_t'(s + 1);
                n++;
            end
        end
        for (int k = 0; k < row_filler[row]; k++) begin
            r = int'($urandom % 32'd250);
            block[n] = (r == 0) ? 8'd0 : sram_word_t'(r + 6);   // 0 or 7..255
            n++;
        end
        check_value($sformatf("row %0d block length", row), LEN, n);
        for (int i = LEN - 1; i > 0; i--) begin
            j = int'($urandom % 32'(i + 1));
            tmp      = block[i];
            block[i] = block[j];
            block[j] = tmp;
        end
    endtask

    task automatic load_block();
        for (int i = 0; i < LEN; i++)
            i_sram_model.load_word(sram_addr_t'(`HUFF_INPUT_BASE + i), block[i]);
    endtask

    task automatic clear_results();
        sram_addr_t addr;
        for (int i = 0; i < 2 * NSYM; i++) begin
            addr = sram_addr_t'(`HUFF_RESULT_BASE + i);
            i_sram_model.load_word(addr, scrub_word(addr));
        end
    endtask

    task automatic reset_dut();
        @(negedge clk);
        reset = 1'b1;
        repeat (8) @(negedge clk);
        check_value("finish cleared by reset", 0, int'(finish));
        reset = 1'b0;
    endtask

    task automatic wait_finish();
        int cycles;
        cycles = 0;
        while (finish !== 1'b1) begin
            if (cycles == TIMEOUT_CYCLES)
                stop_on_timeout("finish never rose after reset release");
            @(negedge clk);
            cycles++;
        end
    endtask

    // highest count first, lower symbol wins a tie
    function automatic void rank_reference(input int row);
        bit used [NSYM];
        int best;
        for (int s = 0; s < NSYM; s++)
            used[s] = 1'b0;
        for (int r = 0; r < NSYM; r++) begin
            best = -1;
            for (int s = 0; s < NSYM; s++) begin
                if (!used[s] && ((best < 0) || (row_counts[row][s] > row_counts[row][best])))
                    best = s;
            end
            used[best] = 1'b1;
            exp_sym[r] = best + 1;
            exp_cnt[r] = row_counts[row][best];
        end
    endfunction

    task automatic check_results(input int row);
        sram_word_t sym_w;
        sram_word_t cnt_w;
        sram_word_t word;
        int         addr;
        int         prev_cnt;
        int         prev_sym;
        int         n;
        rank_reference(row);
        prev_cnt = -1;
        prev_sym = 0;
        for (int r = 0; r < NSYM; r++) begin
            addr = `HUFF_RESULT_BASE + 2 * r;
            i_sram_model.read_word(sram_addr_t'(addr), sym_w);
            i_sram_model.read_word(sram_addr_t'(addr + 1), cnt_w);
            check_value($sformatf("row %0d rank %0d symbol", row, r), exp_sym[r], int'(sym_w));
            check_value($sformatf("row %0d rank %0d count", row, r),
                        row_counts[row][int'(sym_w) - 1], int'(cnt_w));
            check_value($sformatf("row %0d rank %0d reference count", row, r),
                        exp_cnt[r], int'(cnt_w));
            if (prev_cnt == 0) begin
                // zero counts trail in symbol order
                check_value($sformatf("row %0d rank %0d zero tail", row, r), 0, int'(cnt_w));
                check_value($sformatf("row %0d rank %0d zero tail order", row, r),
                            1, (int'(sym_w) > prev_sym) ? 1 : 0);
            end
            prev_cnt = int'(cnt_w);
            prev_sym = int'(sym_w);
        end
        for (int i = 0; i < LEN; i++) begin
            i_sram_model.read_word(sram_addr_t'(`HUFF_INPUT_BASE + i), word);
            check_value($sformatf("row %0d input word %0d", row, i), int'(block[i]), int'(word));
        end
        i_sram_model.get_input_writes(n);
        check_value("writes into the input block", 0, n);
    endtask

    task automatic check_finish_hold();
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            @(negedge clk);
            check_value("finish held high", 1, int'(finish));
            check_value("write after finish", 0, int'(sram_wen));
        end
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        void'($urandom(32'h89fa_5515));
        for (int row = 0; row < NUM_ROWS; row++) begin
            build_block(row);
            load_block();
            clear_results();
            reset_dut();
            wait_finish();
            check_value("write still pending at finish", 0, int'(sram_wen));
            check_results(row);
            check_finish_hold();
        end
        reset_dut();   // finish must drop again
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
rtl/huff_sram_pkg.sv
rtl/huff_rank_pkg.sv
rtl/symbol_reader.sv
rtl/symbol_bin.sv
rtl/rank_sorter.sv
rtl/rank_writer.sv
rtl/huff_freq_rank.sv
test/tb_sram_model.sv
test/tb_huff_rank.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile with Verilator, run, and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f list.f --top-module tb_huff_rank \
    -o tb_huff_rank > "$LOG" 2>&1 \
    && ./obj_dir/tb_huff_rank >> "$LOG" 2>&1 \
    || echo "*** TEST FAILED ***" >> "$LOG"

cat "$LOG"
grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG" && exit 1 || exit 0
